// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_exu
FILELIST  := src.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== ex_alu.sv ====
// integer alu and branch compare
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  exu_pkg::alu_op_e alu_op,
    input  exu_pkg::word_t   op1,
    input  exu_pkg::word_t   op2,
    output exu_pkg::word_t   alu_out,
    output logic             comp
);

    logic [4:0] shamt;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = op2[4:0];

    // compares shared by slt/sltu and the branch ops
    assign eq   = (op1 == op2);
    assign lt_s = ($signed(op1) < $signed(op2));
    assign lt_u = (op1 < op2);

    always_comb begin
        alu_out = '0;
        comp    = 1'b0;
        case (alu_op)
            exu_pkg::alu_add:  alu_out = op1 + op2;
            exu_pkg::alu_sub:  alu_out = op1 - op2;
            exu_pkg::alu_sll:  alu_out = op1 << shamt;
            exu_pkg::alu_slt:  alu_out = {{(exu_pkg::xlen-1){1'b0}}, lt_s};
            exu_pkg::alu_sltu: alu_out = {{(exu_pkg::xlen-1){1'b0}}, lt_u};
            exu_pkg::alu_xor:  alu_out = op1 ^ op2;
            exu_pkg::alu_srl:  alu_out = op1 >> shamt;
            exu_pkg::alu_sra:  alu_out = $signed(op1) >>> shamt;
            exu_pkg::alu_or:   alu_out = op1 | op2;
            exu_pkg::alu_and:  alu_out = op1 & op2;
            // branch conditions leave alu_out at zero
            exu_pkg::alu_beq:  comp = eq;
            exu_pkg::alu_bne:  comp = !eq;
            exu_pkg::alu_blt:  comp = lt_s;
            exu_pkg::alu_bge:  comp = !lt_s;
            exu_pkg::alu_bltu: comp = lt_u;
            exu_pkg::alu_bgeu: comp = !lt_u;
        endcase
    end

endmodule

`default_nettype wire

// ==== ex_branch.sv ====
// branch target and redirect
`timescale 1ns/1ps
`default_nettype none

module ex_branch (
    input  exu_pkg::id_ex_t ex_q,
    input  exu_pkg::word_t  alu_out,
    input  wire logic       comp,
    input  wire logic       flush,
    output exu_pkg::word_t  pc_imm,
    output logic            jump_valid,
    output exu_pkg::word_t  jump_pc
);

    logic           taken;
    exu_pkg::word_t jalr_target;

    assign pc_imm = ex_q.pc + ex_q.imm;

    // jalr adds rs1 and imm in the alu, bit 0 is dropped
    assign jalr_target = {alu_out[exu_pkg::xlen-1:1], 1'b0};

    assign jump_pc = ex_q.ctrl.jalr ? jalr_target : pc_imm;

    // not-taken is predicted, so any taken control flow redirects
    assign taken = ex_q.ctrl.jal || ex_q.ctrl.jalr ||
                   (ex_q.ctrl.branch && comp);

    assign jump_valid = ex_q.valid && !flush && taken;

endmodule

`default_nettype wire

// ==== ex_operand.sv ====
// operand forwarding and select
`timescale 1ns/1ps
`default_nettype none

module ex_operand (
    input  exu_pkg::id_ex_t ex_q,
    input  exu_pkg::fwd_t   lsu_fwd,
    input  exu_pkg::fwd_t   wb_fwd,
    output exu_pkg::word_t  src1,
    output exu_pkg::word_t  src2,
    output exu_pkg::word_t  op1,
    output exu_pkg::word_t  op2
);

    // true when a later-stage write targets this source index
    function automatic logic fwd_hit(
        input exu_pkg::fwd_t     fwd,
        input exu_pkg::reg_addr_t idx
    );
        return fwd.we && (fwd.rd != '0) && (fwd.rd == idx);
    endfunction

    logic lsu_rs1_hit;
    logic lsu_rs2_hit;
    logic wb_rs1_hit;
    logic wb_rs2_hit;

    assign lsu_rs1_hit = fwd_hit(lsu_fwd, ex_q.rs1);
    assign lsu_rs2_hit = fwd_hit(lsu_fwd, ex_q.rs2);
    assign wb_rs1_hit  = fwd_hit(wb_fwd, ex_q.rs1);
    assign wb_rs2_hit  = fwd_hit(wb_fwd, ex_q.rs2);

    // memory stage is newer than write-back, so it goes first
    assign src1 = lsu_rs1_hit ? lsu_fwd.data :
                  wb_rs1_hit  ? wb_fwd.data  :
                  ex_q.rd1;

    assign src2 = lsu_rs2_hit ? lsu_fwd.data :
                  wb_rs2_hit  ? wb_fwd.data  :
                  ex_q.rd2;

    assign op1 = src1;

    // immediate forms use imm as the second operand
    assign op2 = ex_q.ctrl.op2_imm ? ex_q.imm : src2;

endmodule

`default_nettype wire

// ==== ex_result.sv ====
// result select and memory stage bundle
`timescale 1ns/1ps
`default_nettype none

module ex_result (
    input  exu_pkg::id_ex_t  ex_q,
    input  exu_pkg::word_t   alu_out,
    input  exu_pkg::word_t   pc_imm,
    input  exu_pkg::word_t   src2,
    input  wire logic        flush,
    output exu_pkg::ex_mem_t ex_mem
);

    exu_pkg::word_t dout;
    exu_pkg::word_t pc_plus;
    logic           live;

    // link value for jal and jalr
    assign pc_plus = ex_q.pc + exu_pkg::pc_step;

    always_comb begin
        case (ex_q.ctrl.res_sel)
            exu_pkg::res_alu:     dout = alu_out;
            exu_pkg::res_pc_imm:  dout = pc_imm;
            exu_pkg::res_pc_plus: dout = pc_plus;
            exu_pkg::res_imm:     dout = ex_q.imm;
            default:              dout = alu_out;
        endcase
    end

    // a flushed instruction keeps its data but loses all strobes
    assign live = ex_q.valid && !flush;

    always_comb begin
        ex_mem            = '0;
        ex_mem.valid      = live;
        ex_mem.pc         = ex_q.pc;
        ex_mem.rd         = ex_q.rd;
        ex_mem.rf_we      = live && ex_q.ctrl.rf_we;
        ex_mem.mem_we     = live && ex_q.ctrl.mem_we;
        ex_mem.mem_re     = live && ex_q.ctrl.mem_re;
        ex_mem.mem_size   = ex_q.ctrl.mem_size;
        ex_mem.dout       = dout;
        ex_mem.store_data = src2;
    end

endmodule

`default_nettype wire

// ==== ex_stage_reg.sv ====
// execute stage register
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg (
    input  wire logic           clk,
    input  wire logic           rstn,
    input  wire logic           stall,
    input  exu_pkg::id_ex_t     id_ex,
    output exu_pkg::id_ex_t     ex_q
);

    exu_pkg::id_ex_t held_q;

    // loads a new instruction on every edge without stall
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            held_q <= '0;
        end else if (!stall) begin
            held_q <= id_ex;
        end
    end

    // fields are unpacked through the struct at each receiver
    assign ex_q = held_q;

endmodule

`default_nettype wire

// ==== exu.sv ====
// execute stage top
`timescale 1ns/1ps
`default_nettype none

module exu (
    input  wire logic        clk,
    input  wire logic        rstn,
    input  exu_pkg::id_ex_t  id_ex,
    input  exu_pkg::fwd_t    lsu_fwd,
    input  exu_pkg::fwd_t    wb_fwd,
    input  wire logic        stall,
    input  wire logic        flush,
    output exu_pkg::ex_mem_t ex_mem,
    output logic             jump_valid,
    output exu_pkg::word_t   jump_pc
);

    exu_pkg::id_ex_t ex_q;
    exu_pkg::word_t  src1;
    exu_pkg::word_t  src2;
    exu_pkg::word_t  op1;
    exu_pkg::word_t  op2;
    exu_pkg::word_t  alu_out;
    exu_pkg::word_t  pc_imm;
    logic            comp;

    // decode side
    ex_stage_reg stage_reg_i (
        .clk   (clk),
        .rstn  (rstn),
        .stall (stall),
        .id_ex (id_ex),
        .ex_q  (ex_q)
    );

    // execute side
    ex_operand operand_i (
        .ex_q    (ex_q),
        .lsu_fwd (lsu_fwd),
        .wb_fwd  (wb_fwd),
        .src1    (src1),
        .src2    (src2),
        .op1     (op1),
        .op2     (op2)
    );

    ex_alu alu_i (
        .alu_op  (ex_q.ctrl.alu_op),
        .op1     (op1),
        .op2     (op2),
        .alu_out (alu_out),
        .comp    (comp)
    );

    ex_branch branch_i (
        .ex_q       (ex_q),
        .alu_out    (alu_out),
        .comp       (comp),
        .flush      (flush),
        .pc_imm     (pc_imm),
        .jump_valid (jump_valid),
        .jump_pc    (jump_pc)
    );

    // result side
    ex_result result_i (
        .ex_q    (ex_q),
        .alu_out (alu_out),
        .pc_imm  (pc_imm),
        .src2    (src2),
        .flush   (flush),
        .ex_mem  (ex_mem)
    );

endmodule

`default_nettype wire

// ==== exu_pkg.sv ====
// execute stage shared types
`default_nettype none

package exu_pkg;

    // RV32 data and address width
    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;
    // load/store size and sign, same coding as funct3
    typedef logic [2:0]      mem_size_t;

    // distance from pc to the next instruction
    localparam word_t pc_step = 32'd4;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9,
        alu_beq  = 4'd10,
        alu_bne  = 4'd11,
        alu_blt  = 4'd12,
        alu_bge  = 4'd13,
        alu_bltu = 4'd14,
        alu_bgeu = 4'd15
    } alu_op_e;

    // value sent on as register write data or memory address
    typedef enum logic [1:0] {
        res_alu     = 2'd0,
        res_pc_imm  = 2'd1,
        res_pc_plus = 2'd2,
        res_imm     = 2'd3
    } res_sel_e;

    typedef struct packed {
        logic      rf_we;
        logic      op2_imm;
        alu_op_e   alu_op;
        res_sel_e  res_sel;
        logic      mem_we;
        logic      mem_re;
        mem_size_t mem_size;
        logic      branch;
        logic      jal;
        logic      jalr;
    } ex_ctrl_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rd1;
        word_t     rd2;
        ex_ctrl_t  ctrl;
    } id_ex_t;

    // one register file write seen in a later stage
    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rd;
        logic      rf_we;
        logic      mem_we;
        logic      mem_re;
        mem_size_t mem_size;
        word_t     dout;
        word_t     store_data;
    } ex_mem_t;

endpackage

`default_nettype wire

// ==== exu_props.sv ====
// execute stage properties
`timescale 1ns/1ps
`default_nettype none

module exu_props (
    input wire logic             clk,
    input wire logic             rstn,
    input wire logic             stall,
    input wire logic             flush,
    input wire exu_pkg::ex_mem_t ex_mem,
    input wire logic             jump_valid
);

    // a flushed stage drives no strobe
    flush_gates_strobes: assert property (@(posedge clk) disable iff (!rstn)
        flush |-> !(ex_mem.valid || ex_mem.rf_we || ex_mem.mem_we || ex_mem.mem_re
                    || jump_valid))
        else $error("strobe high while flush is set");

    // no redirect while reset is held
    no_jump_in_reset: assert property (@(posedge clk) !rstn |-> !jump_valid)
        else $error("jump_valid high during reset");

    // held instruction survives a stalled edge
    stall_holds_stage: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> ($stable(ex_mem.pc) && $stable(ex_mem.rd)))
        else $error("held pc or rd changed across a stall");

endmodule

bind exu exu_props props_i (
    .clk        (clk),
    .rstn       (rstn),
    .stall      (stall),
    .flush      (flush),
    .ex_mem     (ex_mem),
    .jump_valid (jump_valid)
);

`default_nettype wire

// ==== src.f ====
exu_pkg.sv
ex_stage_reg.sv
ex_operand.sv
ex_alu.sv
ex_branch.sv
ex_result.sv
exu.sv
exu_props.sv
tb_exu.sv

// ==== tb_exu.sv ====
// execute stage testbench
`timescale 1ns/1ps
`default_nettype none

module tb_exu;

    typedef struct packed {
        exu_pkg::id_ex_t    id_ex;
        exu_pkg::fwd_t      lsu_fwd;
        exu_pkg::fwd_t      wb_fwd;
        logic               stall;
        logic               flush;
        exu_pkg::word_t     exp_pc;
        exu_pkg::reg_addr_t exp_rd;
        exu_pkg::mem_size_t exp_size;
        exu_pkg::word_t     exp_dout;
        exu_pkg::word_t     exp_store;
        logic [3:0]         exp_flags;
        logic               exp_jv;
        exu_pkg::word_t     exp_jpc;
    } entry_t;

    logic             clk = 1'b0;
    logic             rstn;
    exu_pkg::id_ex_t  id_ex;
    exu_pkg::fwd_t    lsu_fwd;
    exu_pkg::fwd_t    wb_fwd;
    logic             stall;
    logic             flush;
    exu_pkg::ex_mem_t ex_mem;
    logic             jump_valid;
    exu_pkg::word_t   jump_pc;

    entry_t           table_q[$];
    // instruction the model believes the stage register holds
    exu_pkg::id_ex_t  model_held = '0;
    logic [31:0]      rng_state = 32'he6b0;

    exu dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .id_ex      (id_ex),
        .lsu_fwd    (lsu_fwd),
        .wb_fwd     (wb_fwd),
        .stall      (stall),
        .flush      (flush),
        .ex_mem     (ex_mem),
        .jump_valid (jump_valid),
        .jump_pc    (jump_pc)
    );

    always #20 clk = ~clk;

    // linear congruential generator
    function automatic exu_pkg::word_t rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic signed_less(exu_pkg::word_t a, exu_pkg::word_t b);
        return (a[31] != b[31]) ? a[31] : (a < b);
    endfunction

    function automatic exu_pkg::word_t ref_alu(exu_pkg::alu_op_e op, exu_pkg::word_t a,
                                               exu_pkg::word_t b);
        logic [63:0] wide;
        // sign filled copy for arithmetic right shift
        wide = {{32{a[31]}}, a} >> b[4:0];
        case (op)
            exu_pkg::alu_add:  return a + b;
            exu_pkg::alu_sub:  return a + ~b + 32'd1;
            exu_pkg::alu_sll:  return a << b[4:0];
            exu_pkg::alu_slt:  return {31'd0, signed_less(a, b)};
            exu_pkg::alu_sltu: return {31'd0, a < b};
            exu_pkg::alu_xor:  return a ^ b;
            exu_pkg::alu_srl:  return a >> b[4:0];
            exu_pkg::alu_sra:  return wide[31:0];
            exu_pkg::alu_or:   return a | b;
            exu_pkg::alu_and:  return a & b;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic logic ref_taken(exu_pkg::alu_op_e op, exu_pkg::word_t a,
                                       exu_pkg::word_t b);
        case (op)
            exu_pkg::alu_beq:  return a == b;
            exu_pkg::alu_bne:  return a != b;
            exu_pkg::alu_blt:  return signed_less(a, b);
            exu_pkg::alu_bge:  return !signed_less(a, b);
            exu_pkg::alu_bltu: return a < b;
            exu_pkg::alu_bgeu: return a >= b;
            default:           return 1'b0;
        endcase
    endfunction

    // newest matching write wins, x0 is never forwarded
    function automatic exu_pkg::word_t pick_src(exu_pkg::reg_addr_t idx, exu_pkg::word_t rf_val,
                                                exu_pkg::fwd_t lsu, exu_pkg::fwd_t wb);
        if (lsu.we && idx != 5'd0 && lsu.rd == idx) return lsu.data;
        if (wb.we && idx != 5'd0 && wb.rd == idx) return wb.data;
        return rf_val;
    endfunction

    function automatic exu_pkg::fwd_t mk_fwd(logic we, exu_pkg::reg_addr_t rd,
                                             exu_pkg::word_t data);
        return '{we, rd, data};
    endfunction

    // valid instruction reading x1 and x2, writing x3
    function automatic exu_pkg::id_ex_t mk_id(exu_pkg::alu_op_e op, logic op2_imm,
                                              exu_pkg::res_sel_e sel, exu_pkg::word_t rd1,
                                              exu_pkg::word_t rd2, exu_pkg::word_t imm);
        exu_pkg::id_ex_t id;
        id              = '0;
        id.valid        = 1'b1;
        id.rs1          = 5'd1;
        id.rs2          = 5'd2;
        id.rd           = 5'd3;
        id.rd1          = rd1;
        id.rd2          = rd2;
        id.imm          = imm;
        id.ctrl.rf_we   = 1'b1;
        id.ctrl.op2_imm = op2_imm;
        id.ctrl.alu_op  = op;
        id.ctrl.res_sel = sel;
        return id;
    endfunction

    function automatic void push_entry(exu_pkg::id_ex_t id, exu_pkg::fwd_t lsu,
                                       exu_pkg::fwd_t wb, logic stall_v, logic flush_v);
        entry_t          e;
        exu_pkg::id_ex_t h;
        exu_pkg::word_t  s1;
        exu_pkg::word_t  s2;
        exu_pkg::word_t  op2;
        exu_pkg::word_t  alu_v;
        logic            live;
        id.pc = 32'h1000 + 32'(table_q.size()) * 32'd16;
        if (!stall_v) model_held = id;
        h     = model_held;
        s1    = pick_src(h.rs1, h.rd1, lsu, wb);
        s2    = pick_src(h.rs2, h.rd2, lsu, wb);
        op2   = h.ctrl.op2_imm ? h.imm : s2;
        alu_v = ref_alu(h.ctrl.alu_op, s1, op2);
        live  = h.valid && !flush_v;
        case (h.ctrl.res_sel)
            exu_pkg::res_pc_imm:  e.exp_dout = h.pc + h.imm;
            exu_pkg::res_pc_plus: e.exp_dout = h.pc + 32'd4;
            exu_pkg::res_imm:     e.exp_dout = h.imm;
            default:              e.exp_dout = alu_v;
        endcase
        e.id_ex     = id;
        e.lsu_fwd   = lsu;
        e.wb_fwd    = wb;
        e.stall     = stall_v;
        e.flush     = flush_v;
        e.exp_pc    = h.pc;
        e.exp_rd    = h.rd;
        e.exp_size  = h.ctrl.mem_size;
        e.exp_store = s2;
        e.exp_flags = {live, live && h.ctrl.rf_we, live && h.ctrl.mem_we, live && h.ctrl.mem_re};
        e.exp_jv    = live && (h.ctrl.jal || h.ctrl.jalr ||
                               (h.ctrl.branch && ref_taken(h.ctrl.alu_op, s1, op2)));
        // jalr target is rs1 plus imm with bit 0 cleared
        e.exp_jpc   = h.ctrl.jalr ? ((s1 + h.imm) & ~32'd1) : h.pc + h.imm;
        table_q.push_back(e);
    endfunction

    function automatic void build_table();
        exu_pkg::id_ex_t id;
        exu_pkg::fwd_t   idle;
        exu_pkg::word_t  x;
        idle = '0;
        // every op with a register and an immediate second operand
        for (int k = 0; k < 16; k++) begin
            for (int m = 0; m < 2; m++) begin
                id = mk_id(exu_pkg::alu_op_e'(k[3:0]), m[0], exu_pkg::res_alu,
                           rand_word(), rand_word(), rand_word());
                id.ctrl.branch = (k >= 10);
                push_entry(id, idle, idle, 1'b0, 1'b0);
            end
        end
        // forwarding priority and ignored writes
        id = mk_id(exu_pkg::alu_add, 1'b0, exu_pkg::res_alu, rand_word(), rand_word(), 32'd0);
        push_entry(id, mk_fwd(1'b1, 5'd1, rand_word()), mk_fwd(1'b1, 5'd1, rand_word()),
                   1'b0, 1'b0);
        push_entry(id, mk_fwd(1'b1, 5'd1, rand_word()), mk_fwd(1'b1, 5'd2, rand_word()),
                   1'b0, 1'b0);
        push_entry(id, mk_fwd(1'b0, 5'd1, rand_word()), mk_fwd(1'b0, 5'd2, rand_word()),
                   1'b0, 1'b0);
        id.ctrl.op2_imm  = 1'b1;
        id.ctrl.rf_we    = 1'b0;
        id.ctrl.mem_we   = 1'b1;
        id.ctrl.mem_size = 3'b010;
        push_entry(id, mk_fwd(1'b1, 5'd2, rand_word()), mk_fwd(1'b1, 5'd2, rand_word()),
                   1'b0, 1'b0);
        id.rs1 = 5'd0;
        id.rs2 = 5'd0;
        push_entry(id, mk_fwd(1'b1, 5'd0, rand_word()), mk_fwd(1'b1, 5'd0, rand_word()),
                   1'b0, 1'b0);
        // branches, jumps and the other result selects
        x  = rand_word();
        id = mk_id(exu_pkg::alu_beq, 1'b0, exu_pkg::res_alu, x, x, 32'h40);
        id.ctrl.branch = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id.ctrl.alu_op = exu_pkg::alu_bne;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id = mk_id(exu_pkg::alu_blt, 1'b0, exu_pkg::res_alu, 32'hffff_fff0, 32'h10, 32'hff0);
        id.ctrl.branch = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id.ctrl.alu_op = exu_pkg::alu_bgeu;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id = mk_id(exu_pkg::alu_add, 1'b1, exu_pkg::res_pc_plus, rand_word(), 32'd0, 32'h800);
        id.ctrl.jal = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id = mk_id(exu_pkg::alu_add, 1'b1, exu_pkg::res_pc_plus, 32'h2001, 32'd0, 32'h10);
        id.ctrl.jalr = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id = mk_id(exu_pkg::alu_add, 1'b1, exu_pkg::res_pc_imm, rand_word(), 32'd0, 32'h12000);
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id.ctrl.res_sel = exu_pkg::res_imm;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        // load, then flushed load and flushed store with jal
        id = mk_id(exu_pkg::alu_add, 1'b1, exu_pkg::res_alu, rand_word(), rand_word(), 32'h20);
        id.ctrl.mem_re = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        push_entry(id, idle, idle, 1'b0, 1'b1);
        id.ctrl.mem_re = 1'b0;
        id.ctrl.mem_we = 1'b1;
        id.ctrl.jal    = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b1);
        // stall keeps the previous instruction while forwards still act
        id = mk_id(exu_pkg::alu_xor, 1'b0, exu_pkg::res_alu, rand_word(), rand_word(), 32'd0);
        id.rd = 5'd9;
        push_entry(id, idle, idle, 1'b0, 1'b0);
        id = mk_id(exu_pkg::alu_sub, 1'b1, exu_pkg::res_imm, rand_word(), rand_word(), 32'h7);
        push_entry(id, mk_fwd(1'b1, 5'd2, rand_word()), idle, 1'b1, 1'b0);
        push_entry(id, idle, mk_fwd(1'b1, 5'd1, rand_word()), 1'b1, 1'b1);
        push_entry(id, idle, idle, 1'b0, 1'b0);
        // invalid instruction raises no strobe
        id.valid    = 1'b0;
        id.ctrl.jal = 1'b1;
        push_entry(id, idle, idle, 1'b0, 1'b0);
    endfunction

    task automatic fail_now(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(string name, exu_pkg::word_t got, exu_pkg::word_t exp);
        assert (got === exp) else
            fail_now($sformatf("MISMATCH at %0t: %s got %h expected %h",
                               $time, name, got, exp));
    endtask

    task automatic check_entry(entry_t e);
        check_word("ex_mem.pc", ex_mem.pc, e.exp_pc);
        check_word("ex_mem.rd", {27'd0, ex_mem.rd}, {27'd0, e.exp_rd});
        check_word("ex_mem.mem_size", {29'd0, ex_mem.mem_size}, {29'd0, e.exp_size});
        check_word("ex_mem.dout", ex_mem.dout, e.exp_dout);
        check_word("ex_mem.store_data", ex_mem.store_data, e.exp_store);
        check_word("ex_mem.{valid,rf_we,mem_we,mem_re}",
                   {28'd0, ex_mem.valid, ex_mem.rf_we, ex_mem.mem_we, ex_mem.mem_re},
                   {28'd0, e.exp_flags});
        check_word("jump_valid", {31'd0, jump_valid}, {31'd0, e.exp_jv});
        check_word("jump_pc", jump_pc, e.exp_jpc);
    endtask

    initial begin
        int n;
        rstn    = 1'b1;
        // live instruction with every strobe, captured before reset
        id_ex   = mk_id(exu_pkg::alu_add, 1'b0, exu_pkg::res_alu, 32'd0, 32'd0, 32'd0);
        id_ex.ctrl.mem_we = 1'b1;
        id_ex.ctrl.mem_re = 1'b1;
        id_ex.ctrl.jal    = 1'b1;
        lsu_fwd = '0;
        wb_fwd  = '0;
        stall   = 1'b0;
        flush   = 1'b0;
        build_table();
        @(posedge clk);
        rstn <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
        n = 0;
        while (rstn !== 1'b1 && n < 4) begin
            @(negedge clk);
            n++;
        end
        assert (rstn === 1'b1) else fail_now("timeout: reset was never released");
        check_word("ex_mem.{valid,rf_we,mem_we,mem_re}",
                   {28'd0, ex_mem.valid, ex_mem.rf_we, ex_mem.mem_we, ex_mem.mem_re}, 32'd0);
        check_word("jump_valid", {31'd0, jump_valid}, 32'd0);
        foreach (table_q[i]) begin
            @(posedge clk);
            id_ex   <= table_q[i].id_ex;
            lsu_fwd <= table_q[i].lsu_fwd;
            wb_fwd  <= table_q[i].wb_fwd;
            stall   <= table_q[i].stall;
            flush   <= table_q[i].flush;
            // past the drive edge and the load edge
            repeat (2) @(negedge clk);
            check_entry(table_q[i]);
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
